/* board_test_top.f */
link_pkg.sv
switch_debounce.sv
case_select.sv
packet_source.sv
packet_sink.sv
debug_view.sv
board_test_top.sv
tb_clock.sv
tb_board_test.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_board_test -f board_test_top.f

./obj_dir/Vtb_board_test | tee sim.log

grep -q "^TEST PASSED$" sim.log

/* tb_board_test.sv */
`timescale 1ns/1ps

module tb_board_test;

	localparam int SRC_ADDR = 3;
	localparam int MIN_ADDR = 1;
	localparam int MAX_ADDR = 14;
	localparam int WAIT_LIMIT = 200;

	logic       clk;
	logic       rst;
	logic [3:0] sw;
	logic [6:0] seg1;
	logic [6:0] seg2;
	logic [3:0] led;
	logic [3:0] sel_hi;
	logic [3:0] sel_lo;
	logic [7:0] good_ref;
	logic [7:0] recv_ref;
	int         error_cnt;
	int         timeout_cnt;

	tb_clock #(.HALF_NS(20), .RST_CYCLES(8)) u_clock (.o_clk(clk), .o_rst(rst));

	board_test_top #(
		.DEBOUNCE_LEN(8), .SRC_DIV(4), .SRC_ADDR(SRC_ADDR),
		.MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR)
	) u_board_test_top (
		.i_clk(clk), .i_rst(rst), .i_sw_1(sw[0]), .i_sw_2(sw[1]), .i_sw_3(sw[2]),
		.i_sw_4(sw[3]), .o_seg1(seg1), .o_seg2(seg2), .o_led(led)
	);

	// Active-low digit back to a nibble with bit 4 set for an unknown pattern
	function automatic logic [4:0] seg_to_hex(input logic [6:0] seg);
		case (~seg)
			7'b1111110: return 5'h00;
			7'b0110000: return 5'h01;
			7'b1101101: return 5'h02;
			7'b1111001: return 5'h03;
			7'b0110011: return 5'h04;
			7'b1011011: return 5'h05;
			7'b1011111: return 5'h06;
			7'b1110000: return 5'h07;
			7'b1111111: return 5'h08;
			7'b1111011: return 5'h09;
			7'b1110111: return 5'h0a;
			7'b0011111: return 5'h0b;
			7'b1001110: return 5'h0c;
			7'b0111101: return 5'h0d;
			7'b1001111: return 5'h0e;
			7'b1000111: return 5'h0f;
			default: return 5'h10;
		endcase
	endfunction

	task automatic tick(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic press(input logic [3:0] mask);
		sw = mask;
		tick(20);
		sw = 4'b0000;
		tick(20);
	endtask

	task automatic read_display(output logic [7:0] val);
		logic [4:0] hi;
		logic [4:0] lo;
		hi = seg_to_hex(seg1);
		lo = seg_to_hex(seg2);
		assert (!hi[4] && !lo[4]) else begin
			error_cnt++;
			$display("Digits show a pattern that is not a hex digit: %b %b", seg1, seg2);
		end
		val = {hi[3:0], lo[3:0]};
	endtask

	task automatic expect_display(input string name, input logic [7:0] exp);
		logic [7:0] val;
		int         n;
		n = 0;
		read_display(val);
		while (val != exp && n < WAIT_LIMIT) begin
			tick(1);
			read_display(val);
			n++;
		end
		assert (val == exp) else begin
			error_cnt++;
			$display("MISMATCH %s expected %02h actual %02h", name, exp, val);
		end
	endtask

	task automatic check_led(input string name, input logic [3:0] exp);
		assert (led == exp) else begin
			error_cnt++;
			$display("MISMATCH %s expected led %04b actual %04b", name, exp, led);
		end
	endtask

	task automatic wait_led(input int idx, input logic val, input string what);
		int n;
		n = 0;
		while (led[idx] != val && n < WAIT_LIMIT) begin
			tick(1);
			n++;
		end
		assert (led[idx] == val) else begin
			timeout_cnt++;
			$display("Timeout: LED %0d never became %0d during %s", idx, val, what);
		end
	endtask

	// Nibbles wrap so each one steps forward to the target
	task automatic set_case(input logic [7:0] target);
		logic [3:0] hi_steps;
		logic [3:0] lo_steps;
		hi_steps = target[7:4] - sel_hi;
		lo_steps = target[3:0] - sel_lo;
		repeat (hi_steps) press(4'b0001);
		repeat (lo_steps) press(4'b0010);
		sel_hi = target[7:4];
		sel_lo = target[3:0];
	endtask

	task automatic show_case(input logic [7:0] target);
		set_case(target);
		press(4'b1100);
	endtask

	task automatic test_reset();
		expect_display("reset digits", 8'h00);
		check_led("reset leds", 4'b0000);
	endtask

	task automatic test_case_select();
		set_case(8'h13);
		expect_display("case select before latch", 8'h00);
		press(4'b1100);
		expect_display("case select latched", 8'h13);
		check_led("case select leds", 4'b0000);
	endtask

	task automatic test_traffic();
		logic [7:0] sent;
		press(4'b0100);
		wait_led(0, 1'b1, "traffic start");
		tick(400);
		press(4'b0100);
		wait_led(0, 1'b0, "traffic stop");
		show_case(8'h00);
		wait_led(2, 1'b1, "latch of case 0");
		read_display(sent);
		assert (sent != 8'h00) else begin
			error_cnt++;
			$display("Traffic test: the sent counter stayed at zero");
		end
		show_case(8'h01);
		expect_display("traffic received", sent);
		show_case(8'h02);
		expect_display("traffic good", sent);
		show_case(8'h03);
		expect_display("traffic bad", 8'h00);
		recv_ref = sent;
		good_ref = sent;
	endtask

	task automatic test_last_packet();
		logic [3:0] dst;
		logic [3:0] dat;
		logic [3:0] red;
		int         n;
		n = int'(recv_ref) - 1;
		dst = 4'(MIN_ADDR + n % (MAX_ADDR - MIN_ADDR + 1));
		dat = 4'(n);
		red = 4'(SRC_ADDR) ^ dst ^ dat;
		show_case(8'h04);
		expect_display("last dst dat", {dst, dat});
		show_case(8'h05);
		expect_display("last src red", {4'(SRC_ADDR), red});
		check_led("last packet leds", 4'b1100);
	endtask

	task automatic test_fault();
		logic [7:0] total;
		press(4'b1000);
		wait_led(1, 1'b1, "fault on");
		press(4'b0100);
		wait_led(0, 1'b1, "faulty traffic start");
		tick(400);
		press(4'b0100);
		wait_led(0, 1'b0, "faulty traffic stop");
		show_case(8'h01);
		read_display(total);
		assert (total > recv_ref) else begin
			error_cnt++;
			$display("Fault test: no new packets were received");
		end
		show_case(8'h02);
		expect_display("fault good", good_ref);
		show_case(8'h03);
		expect_display("fault bad", total - good_ref);
		check_led("fault leds", 4'b0110);
	endtask

	initial begin
		int n;
		sw = 4'b0000;
		sel_hi = 4'h0;
		sel_lo = 4'h0;
		good_ref = 8'h00;
		recv_ref = 8'h00;
		error_cnt = 0;
		timeout_cnt = 0;
		n = 0;
		tick(1);
		while (rst && n < 50) begin
			tick(1);
			n++;
		end
		assert (!rst) else begin
			timeout_cnt++;
			$display("Timeout: reset was never released");
		end
		test_reset();
		test_case_select();
		test_traffic();
		test_last_packet();
		test_fault();
		$display("Errors: %0d mismatches, %0d timeouts", error_cnt, timeout_cnt);
		if (error_cnt == 0 && timeout_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_NS = 20,
	parameter int RST_CYCLES = 8
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(HALF_NS) o_clk = ~o_clk;
	end

	// Release just after an edge, ahead of the stimulus slot
	initial begin
		o_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge o_clk);
		#1 o_rst = 1'b0;
	end

endmodule

/* board_test_top.sv */
`timescale 1ns/1ps

module board_test_top #(
	parameter int DEBOUNCE_LEN = 250000,
	parameter int SRC_DIV = 100,
	parameter int SRC_ADDR = 3,
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 14
) (
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_sw_1,
	input  logic       i_sw_2,
	input  logic       i_sw_3,
	input  logic       i_sw_4,
	output logic [6:0] o_seg1,
	output logic [6:0] o_seg2,
	output logic [3:0] o_led
);

	import link_pkg::*;

	localparam int DIV_W = (SRC_DIV > 1) ? $clog2(SRC_DIV) : 1;

	logic              sw_1_db;
	logic              sw_2_db;
	logic              sw_3_db;
	logic              sw_4_db;
	logic [CASE_W-1:0] dbg_case;
	logic              dbg_doit;
	logic              run;
	logic              fault;
	logic [DIV_W-1:0]  div_cnt;
	logic              src_en;
	logic              lnk_req;
	logic              lnk_ack;
	logic [PKT_W-1:0]  lnk_pkt;
	logic [CNT_W-1:0]  sent_cnt;
	logic [CNT_W-1:0]  recv_cnt;
	logic [CNT_W-1:0]  good_cnt;
	logic [CNT_W-1:0]  bad_cnt;
	logic [PKT_W-1:0]  last_pkt;

	switch_debounce #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) u_db_1 (
		.i_clk(i_clk), .i_rst(i_rst), .i_sw(i_sw_1), .o_sw(sw_1_db)
	);
	switch_debounce #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) u_db_2 (
		.i_clk(i_clk), .i_rst(i_rst), .i_sw(i_sw_2), .o_sw(sw_2_db)
	);
	switch_debounce #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) u_db_3 (
		.i_clk(i_clk), .i_rst(i_rst), .i_sw(i_sw_3), .o_sw(sw_3_db)
	);
	switch_debounce #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) u_db_4 (
		.i_clk(i_clk), .i_rst(i_rst), .i_sw(i_sw_4), .o_sw(sw_4_db)
	);

	case_select u_case_select (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_sw_1(sw_1_db), .i_sw_2(sw_2_db), .i_sw_3(sw_3_db), .i_sw_4(sw_4_db),
		.o_case(dbg_case), .o_doit(dbg_doit), .o_run(run), .o_fault(fault)
	);

	// One-cycle source strobe every SRC_DIV clocks
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			div_cnt <= '0;
			src_en <= 1'b0;
		end else if (div_cnt == DIV_W'(SRC_DIV - 1)) begin
			div_cnt <= '0;
			src_en <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			src_en <= 1'b0;
		end
	end

	packet_source #(.SRC_ADDR(SRC_ADDR), .MIN_ADDR(MIN_ADDR), .MAX_ADDR(MAX_ADDR)) u_source (
		.i_clk(i_clk), .i_rst(i_rst), .i_en(src_en), .i_run(run), .i_fault(fault),
		.i_ack(lnk_ack), .o_req(lnk_req), .o_pkt(lnk_pkt), .o_sent_cnt(sent_cnt)
	);

	packet_sink u_sink (
		.i_clk(i_clk), .i_rst(i_rst), .i_req(lnk_req), .i_pkt(lnk_pkt), .o_ack(lnk_ack),
		.o_recv_cnt(recv_cnt), .o_good_cnt(good_cnt), .o_bad_cnt(bad_cnt),
		.o_last_pkt(last_pkt)
	);

	debug_view u_view (
		.i_clk(i_clk), .i_rst(i_rst), .i_case(dbg_case), .i_doit(dbg_doit),
		.i_sent_cnt(sent_cnt), .i_recv_cnt(recv_cnt), .i_good_cnt(good_cnt),
		.i_bad_cnt(bad_cnt), .i_last_pkt(last_pkt), .i_run(run), .i_fault(fault),
		.o_seg1(o_seg1), .o_seg2(o_seg2), .o_led(o_led)
	);

endmodule

/* debug_view.sv */
`timescale 1ns/1ps

module debug_view (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic [link_pkg::CASE_W-1:0] i_case,
	input  logic                        i_doit,
	input  logic [link_pkg::CNT_W-1:0]  i_sent_cnt,
	input  logic [link_pkg::CNT_W-1:0]  i_recv_cnt,
	input  logic [link_pkg::CNT_W-1:0]  i_good_cnt,
	input  logic [link_pkg::CNT_W-1:0]  i_bad_cnt,
	input  logic [link_pkg::PKT_W-1:0]  i_last_pkt,
	input  logic                        i_run,
	input  logic                        i_fault,
	output logic [6:0]                  o_seg1,
	output logic [6:0]                  o_seg2,
	output logic [3:0]                  o_led
);

	import link_pkg::*;

	logic [CASE_W-1:0] case_q;
	logic [CASE_W-1:0] sel;
	logic [3:0]        nib_hi;
	logic [3:0]        nib_lo;
	logic              last_good;

	// Segments A..G on bits 6..0, lit high
	function automatic logic [6:0] hex_seg(input logic [3:0] v);
		case (v)
			4'h0: return 7'b1111110;
			4'h1: return 7'b0110000;
			4'h2: return 7'b1101101;
			4'h3: return 7'b1111001;
			4'h4: return 7'b0110011;
			4'h5: return 7'b1011011;
			4'h6: return 7'b1011111;
			4'h7: return 7'b1110000;
			4'h8: return 7'b1111111;
			4'h9: return 7'b1111011;
			4'ha: return 7'b1110111;
			4'hb: return 7'b0011111;
			4'hc: return 7'b1001110;
			4'hd: return 7'b0111101;
			4'he: return 7'b1001111;
			default: return 7'b1000111;
		endcase
	endfunction

	// New case shows up in the same edge it is latched
	assign sel = i_doit ? i_case : case_q;

	always_comb begin
		case (sel)
			CASE_SENT: {nib_hi, nib_lo} = i_sent_cnt;
			CASE_RECEIVED: {nib_hi, nib_lo} = i_recv_cnt;
			CASE_GOOD: {nib_hi, nib_lo} = i_good_cnt;
			CASE_BAD: {nib_hi, nib_lo} = i_bad_cnt;
			CASE_LAST_DST_DAT: begin
				nib_hi = i_last_pkt[DST_LSB +: ADDR_W];
				nib_lo = i_last_pkt[DAT_LSB +: DATA_W];
			end
			CASE_LAST_SRC_RED: begin
				nib_hi = i_last_pkt[SRC_LSB +: ADDR_W];
				nib_lo = i_last_pkt[RED_LSB +: RED_W];
			end
			default: begin
				if (sel >= CASE_W'(NUM_DBG_CASES)) begin
					{nib_hi, nib_lo} = sel;
				end else begin
					nib_hi = 4'h0;
					nib_lo = 4'h0;
				end
			end
		endcase
	end

	// Nothing received yet counts as not good
	assign last_good = (i_recv_cnt != '0) &&
		(calc_red(i_last_pkt[SRC_LSB +: ADDR_W], i_last_pkt[DST_LSB +: ADDR_W],
		i_last_pkt[DAT_LSB +: DATA_W]) == i_last_pkt[RED_LSB +: RED_W]);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			case_q <= '0;
			o_seg1 <= ~hex_seg(4'h0);
			o_seg2 <= ~hex_seg(4'h0);
			o_led <= 4'b0000;
		end else begin
			case_q <= sel;
			o_seg1 <= ~hex_seg(nib_hi);
			o_seg2 <= ~hex_seg(nib_lo);
			o_led <= {last_good, sel < CASE_W'(NUM_DBG_CASES), i_fault, i_run};
		end
	end

endmodule

/* packet_sink.sv */
`timescale 1ns/1ps

module packet_sink (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_req,
	input  logic [link_pkg::PKT_W-1:0] i_pkt,
	output logic                       o_ack,
	output logic [link_pkg::CNT_W-1:0] o_recv_cnt,
	output logic [link_pkg::CNT_W-1:0] o_good_cnt,
	output logic [link_pkg::CNT_W-1:0] o_bad_cnt,
	output logic [link_pkg::PKT_W-1:0] o_last_pkt
);

	import link_pkg::*;

	logic             req_q;
	logic             req_rise;
	logic             pkt_good;
	logic [RED_W-1:0] red_calc;

	assign req_rise = i_req && !req_q;

	assign red_calc = calc_red(i_pkt[SRC_LSB +: ADDR_W], i_pkt[DST_LSB +: ADDR_W],
		i_pkt[DAT_LSB +: DATA_W]);
	assign pkt_good = (red_calc == i_pkt[RED_LSB +: RED_W]);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			req_q <= 1'b0;
			o_ack <= 1'b0;
			o_recv_cnt <= '0;
			o_good_cnt <= '0;
			o_bad_cnt <= '0;
		end else begin
			req_q <= i_req;
			o_ack <= req_rise;
			if (req_rise) begin
				if (o_recv_cnt != '1) begin
					o_recv_cnt <= o_recv_cnt + 1'b1;
				end
				if (pkt_good && o_good_cnt != '1) begin
					o_good_cnt <= o_good_cnt + 1'b1;
				end
				if (!pkt_good && o_bad_cnt != '1) begin
					o_bad_cnt <= o_bad_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_last_pkt <= '0;
		end else if (req_rise) begin
			o_last_pkt <= i_pkt;
		end
	end

endmodule

/* packet_source.sv */
`timescale 1ns/1ps

module packet_source #(
	parameter int SRC_ADDR = 3,
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 14
) (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_en,
	input  logic                       i_run,
	input  logic                       i_fault,
	input  logic                       i_ack,
	output logic                       o_req,
	output logic [link_pkg::PKT_W-1:0] o_pkt,
	output logic [link_pkg::CNT_W-1:0] o_sent_cnt
);

	import link_pkg::*;

	logic [ADDR_W-1:0] src_addr;
	logic [ADDR_W-1:0] dst_ptr;
	logic [DATA_W-1:0] dat_cnt;
	logic [RED_W-1:0]  red;
	logic              start;

	assign src_addr = ADDR_W'(SRC_ADDR);

	// Fault flips the low check bit so the sink sees a bad packet
	assign red = calc_red(src_addr, dst_ptr, dat_cnt) ^ RED_W'(i_fault);

	// An open request holds off the next packet
	assign start = i_en && i_run && !o_req;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_req <= 1'b0;
			dst_ptr <= ADDR_W'(MIN_ADDR);
			dat_cnt <= '0;
			o_sent_cnt <= '0;
		end else begin
			if (i_ack) begin
				o_req <= 1'b0;
			end else if (start) begin
				o_req <= 1'b1;
				if (dst_ptr == ADDR_W'(MAX_ADDR)) begin
					dst_ptr <= ADDR_W'(MIN_ADDR);
				end else begin
					dst_ptr <= dst_ptr + 1'b1;
				end
				dat_cnt <= dat_cnt + 1'b1;
				if (o_sent_cnt != '1) begin
					o_sent_cnt <= o_sent_cnt + 1'b1;
				end
			end
		end
	end

	// Payload held while the request is open
	always_ff @(posedge i_clk) begin
		if (start && !i_ack) begin
			o_pkt <= {src_addr, dst_ptr, dat_cnt, red};
		end
	end

endmodule

/* case_select.sv */
`timescale 1ns/1ps

module case_select (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_sw_1,
	input  logic                        i_sw_2,
	input  logic                        i_sw_3,
	input  logic                        i_sw_4,
	output logic [link_pkg::CASE_W-1:0] o_case,
	output logic                        o_doit,
	output logic                        o_run,
	output logic                        o_fault
);

	import link_pkg::*;

	localparam int NIB_W = CASE_W / 2;

	logic [3:0]       sw_now;
	logic [3:0]       sw_prev;
	logic [3:0]       sw_fall;
	logic             both_seen;
	logic             solo;
	logic [NIB_W-1:0] case_hi;
	logic [NIB_W-1:0] case_lo;

	assign sw_now = {i_sw_4, i_sw_3, i_sw_2, i_sw_1};
	assign sw_fall = sw_prev & ~sw_now;

	// Single release with nothing else held and no pending latch gesture
	assign solo = (sw_now == 4'b0000) && !both_seen;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			sw_prev <= 4'b0000;
			both_seen <= 1'b0;
			case_hi <= '0;
			case_lo <= '0;
			o_doit <= 1'b0;
			o_run <= 1'b0;
			o_fault <= 1'b0;
		end else begin
			sw_prev <= sw_now;
			o_doit <= 1'b0;

			if (sw_now[2] && sw_now[3]) begin
				both_seen <= 1'b1;
			end else if (both_seen && sw_now == 4'b0000) begin
				// Latch once everything is let go
				both_seen <= 1'b0;
				o_doit <= 1'b1;
			end

			if (solo) begin
				case (sw_fall)
					4'b0001: case_hi <= case_hi + 1'b1;
					4'b0010: case_lo <= case_lo + 1'b1;
					4'b0100: o_run <= !o_run;
					4'b1000: o_fault <= !o_fault;
					default: ;
				endcase
			end
		end
	end

	assign o_case = {case_hi, case_lo};

endmodule

/* switch_debounce.sv */
`timescale 1ns/1ps

module switch_debounce #(
	parameter int DEBOUNCE_LEN = 250000
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_sw,
	output logic o_sw
);

	localparam int CNT_BITS = $clog2(DEBOUNCE_LEN + 1);

	logic                sw_q;
	logic [CNT_BITS-1:0] stable_cnt;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			sw_q <= 1'b0;
			stable_cnt <= '0;
			o_sw <= 1'b0;
		end else begin
			sw_q <= i_sw;
			if (i_sw != sw_q) begin
				// Input moved, start counting again
				stable_cnt <= '0;
			end else if (stable_cnt == CNT_BITS'(DEBOUNCE_LEN - 1)) begin
				o_sw <= sw_q;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

endmodule

/* link_pkg.sv */
package link_pkg;

	// Packet field widths
	localparam int ADDR_W = 4;
	localparam int DATA_W = 4;
	localparam int RED_W = 4;
	localparam int PKT_W = 2 * ADDR_W + DATA_W + RED_W;

	// Field positions, src in the top bits down to red at the bottom
	localparam int RED_LSB = 0;
	localparam int DAT_LSB = RED_LSB + RED_W;
	localparam int DST_LSB = DAT_LSB + DATA_W;
	localparam int SRC_LSB = DST_LSB + ADDR_W;

	localparam int CNT_W = 8;

	// Debug case number, hi and lo nibble
	localparam int CASE_W = 8;
	localparam int NUM_DBG_CASES = 12;

	localparam logic [CASE_W-1:0] CASE_SENT = CASE_W'(0);
	localparam logic [CASE_W-1:0] CASE_RECEIVED = CASE_W'(1);
	localparam logic [CASE_W-1:0] CASE_GOOD = CASE_W'(2);
	localparam logic [CASE_W-1:0] CASE_BAD = CASE_W'(3);
	localparam logic [CASE_W-1:0] CASE_LAST_DST_DAT = CASE_W'(4);
	localparam logic [CASE_W-1:0] CASE_LAST_SRC_RED = CASE_W'(5);

	// Check nibble over the address and data fields
	function automatic logic [RED_W-1:0] calc_red(
		input logic [ADDR_W-1:0] src,
		input logic [ADDR_W-1:0] dst,
		input logic [DATA_W-1:0] dat
	);
		return RED_W'(src ^ dst ^ dat);
	endfunction

endpackage
